//--- source/mines_pkg.sv
// ################################################
// shared constants, level tables and FSM states of the minesweeper core.
// ################################################
package mines_pkg;

  // storage is always the largest board, indexed by y * BOARD_MAX + x.
  localparam int BOARD_MAX = 16;
  localparam int CELLS     = BOARD_MAX * BOARD_MAX;

  typedef enum logic [1:0] {
    LVL_EASY   = 2'd0,
    LVL_MEDIUM = 2'd1,
    LVL_HARD   = 2'd2
  } level_t;

  // ################################################
  // per-level tables, indexed by level_t.
  // ################################################
  localparam logic [4:0] BOARD_SIDE    [3] = '{5'd8, 5'd10, 5'd16};
  localparam logic [5:0] MINE_COUNT    [3] = '{6'd10, 6'd20, 6'd40};
  // two BCD digits.
  localparam logic [7:0] START_SECONDS [3] = '{8'h99, 8'h80, 8'h60};

  // seed of the mine placement LFSR.
  localparam logic [15:0] MINE_SEED = 16'hACE1;

  typedef enum logic {
    PL_IDLE,
    PL_RUN
  } plant_state_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_PLAY,
    FS_DONE
  } field_state_t;

  // two-digit BCD step down, holds at 00.
  function automatic logic [7:0] bcd_dec(input logic [7:0] value);
    logic [7:0] result;
    if (value[3:0] != 4'd0) result = {value[7:4], value[3:0] - 4'd1};
    else if (value[7:4] != 4'd0) result = {value[7:4] - 4'd1, 4'd9};
    else result = 8'h00;
    return result;
  endfunction

  // two-digit BCD step up with a carry into the tens digit.
  function automatic logic [7:0] bcd_inc(input logic [7:0] value);
    logic [7:0] result;
    if (value[3:0] == 4'd9) result = {value[7:4] + 4'd1, 4'd0};
    else result = {value[7:4], value[3:0] + 4'd1};
    return result;
  endfunction

endpackage

//--- source/game_setup.sv
// ################################################
// level select: a button press latches the round settings and fires start.
// ################################################
module game_setup import mines_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] level_btn,
  output logic       start,
  output level_t     level,
  output logic [4:0] board_side,
  output logic [5:0] mine_count,
  output logic [7:0] start_seconds
);

  logic [2:0] btn_prev;
  logic       press;
  level_t     level_dec;

  // a press is the first cycle with any button high.
  assign press = (|level_btn) && !(|btn_prev);

  // a single button picks hard or medium, anything else falls back to easy.
  always_comb begin
    case (level_btn)
      3'b100:  level_dec = LVL_HARD;
      3'b010:  level_dec = LVL_MEDIUM;
      default: level_dec = LVL_EASY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      btn_prev <= 3'b000;
      start    <= 1'b0;
    end else begin
      btn_prev <= level_btn;
      start    <= press;
    end
  end

  // the settings stay put for the whole round.
  always_ff @(posedge clk) begin
    if (rst) begin
      level         <= LVL_EASY;
      board_side    <= 5'd0;
      mine_count    <= 6'd0;
      start_seconds <= 8'h00;
    end else if (press) begin
      level         <= level_dec;
      board_side    <= BOARD_SIDE[level_dec];
      mine_count    <= MINE_COUNT[level_dec];
      start_seconds <= START_SECONDS[level_dec];
    end
  end

endmodule

//--- source/mine_planter.sv
// ################################################
// pseudo-random mine placement, rerun from the fixed seed on every start.
// ################################################
module mine_planter import mines_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic [4:0]       board_side,
  input  logic [5:0]       mine_count,
  output logic [CELLS-1:0] mine_map,
  output logic             plant_done
);

  plant_state_t state;
  logic [15:0]  lfsr;
  logic [15:0]  lfsr_next;
  logic         feedback;
  logic [3:0]   pos_x;
  logic [3:0]   pos_y;
  logic [7:0]   pos_idx;
  logic         pos_ok;
  logic [5:0]   planted;

  // ################################################
  // LFSR step, x^16 + x^14 + x^13 + x^11 + 1.
  // ################################################
  assign feedback  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
  assign lfsr_next = {lfsr[14:0], feedback};

  // candidate cell comes from the freshly stepped value.
  assign pos_x   = lfsr_next[3:0];
  assign pos_y   = lfsr_next[7:4];
  assign pos_idx = 8'(pos_y * BOARD_MAX) + 8'(pos_x);

  // only empty cells inside the board take a mine.
  assign pos_ok = ({1'b0, pos_x} < board_side) &&
                  ({1'b0, pos_y} < board_side) &&
                  !mine_map[pos_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= PL_IDLE;
      plant_done <= 1'b0;
      planted    <= 6'd0;
    end else begin
      plant_done <= 1'b0;
      if (start) begin
        state   <= PL_RUN;
        planted <= 6'd0;
      end else if (state == PL_RUN && pos_ok) begin
        planted <= planted + 6'd1;
        if (planted + 6'd1 == mine_count) begin
          state      <= PL_IDLE;
          plant_done <= 1'b1;
        end
      end
    end
  end

  // the shift register only moves while placing.
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= MINE_SEED;
    end else if (start) begin
      lfsr <= MINE_SEED;
    end else if (state == PL_RUN) begin
      lfsr <= lfsr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mine_map <= '0;
    end else if (start) begin
      mine_map <= '0;
    end else if (state == PL_RUN && pos_ok) begin
      mine_map[pos_idx] <= 1'b1;
    end
  end

endmodule

//--- source/mine_field.sv
// ################################################
// board state: reveal and flag clicks, neighbor count, win and explosion.
// ################################################
module mine_field import mines_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             plant_done,
  input  logic             stop,
  input  logic [4:0]       board_side,
  input  logic [5:0]       mine_count,
  input  logic [CELLS-1:0] mine_map,
  input  logic [3:0]       cell_x,
  input  logic [3:0]       cell_y,
  input  logic             left,
  input  logic             right,
  output logic             playing,
  output logic             reveal_valid,
  output logic [3:0]       reveal_mines,
  output logic             exploded,
  output logic             won,
  output logic [7:0]       mines_left_bcd
);

  field_state_t     state;
  logic [CELLS-1:0] revealed;
  logic [CELLS-1:0] flagged;
  logic [8:0]       revealed_cnt;
  logic [8:0]       area;
  logic [8:0]       safe_target;
  logic [7:0]       idx;
  logic             in_range;
  logic             accept;
  logic [3:0]       nb_count;

  assign playing     = (state == FS_PLAY);
  assign idx         = 8'(cell_y * BOARD_MAX) + 8'(cell_x);
  assign in_range    = ({1'b0, cell_x} < board_side) && ({1'b0, cell_y} < board_side);
  assign accept      = playing && !stop && in_range && !revealed[idx];
  assign area        = board_side * board_side;
  assign safe_target = area - {3'b000, mine_count};

  // ################################################
  // mined neighbors of the clicked cell, edges clipped to the board.
  // ################################################
  always_comb begin : nb_calc
    int nx;
    int ny;
    nb_count = 4'd0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        nx = int'(cell_x) + dx;
        ny = int'(cell_y) + dy;
        if ((dx != 0 || dy != 0) && nx >= 0 && ny >= 0 &&
            nx < int'(board_side) && ny < int'(board_side)) begin
          if (mine_map[ny * BOARD_MAX + nx]) nb_count = nb_count + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= FS_IDLE;
      revealed       <= '0;
      flagged        <= '0;
      revealed_cnt   <= 9'd0;
      reveal_valid   <= 1'b0;
      reveal_mines   <= 4'd0;
      exploded       <= 1'b0;
      won            <= 1'b0;
      mines_left_bcd <= 8'h00;
    end else begin
      reveal_valid <= 1'b0;
      if (start) begin
        state          <= FS_IDLE;
        revealed       <= '0;
        flagged        <= '0;
        revealed_cnt   <= 9'd0;
        exploded       <= 1'b0;
        won            <= 1'b0;
        mines_left_bcd <= {4'(mine_count / 6'd10), 4'(mine_count % 6'd10)};
      end else begin
        case (state)
          FS_IDLE: if (plant_done) state <= FS_PLAY;
          FS_PLAY: if (stop) state <= FS_DONE;
          default: state <= state;
        endcase

        // left click reveals, flagged cells are protected.
        if (accept && left && !flagged[idx]) begin
          if (mine_map[idx]) begin
            exploded <= 1'b1;
          end else begin
            revealed[idx] <= 1'b1;
            revealed_cnt  <= revealed_cnt + 9'd1;
            reveal_valid  <= 1'b1;
            reveal_mines  <= nb_count;
          end
        end else if (accept && right && !left) begin
          if (flagged[idx]) begin
            flagged[idx]   <= 1'b0;
            mines_left_bcd <= bcd_inc(mines_left_bcd);
          end else if (mines_left_bcd != 8'h00) begin
            flagged[idx]   <= 1'b1;
            mines_left_bcd <= bcd_dec(mines_left_bcd);
          end
        end

        // all safe cells open means the round is won.
        if (playing && !exploded && revealed_cnt == safe_target) won <= 1'b1;
      end
    end
  end

endmodule

//--- source/countdown_timer.sv
// ################################################
// round clock: BCD seconds counting down from the level's start value.
// ################################################
module countdown_timer import mines_pkg::*; #(
  parameter int TICKS_PER_SEC = 65_000_000
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] start_seconds,
  input  logic       playing,
  input  logic       pause,
  input  logic       stop,
  output logic [7:0] seconds_bcd,
  output logic       time_up
);

  localparam int PW = $clog2(TICKS_PER_SEC + 1);

  logic [PW-1:0] presc;
  logic          run;
  logic          sec_tick;

  // paused or stopped cycles leave the prescaler where it is.
  assign run      = playing && !pause && !stop && !time_up;
  assign sec_tick = run && (presc == PW'(TICKS_PER_SEC - 1));

  // ################################################
  // prescaler.
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      presc <= '0;
    end else if (start) begin
      presc <= '0;
    end else if (sec_tick) begin
      presc <= '0;
    end else if (run) begin
      presc <= presc + PW'(1);
    end
  end

  // ################################################
  // seconds down-counter.
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      seconds_bcd <= 8'h00;
      time_up     <= 1'b0;
    end else if (start) begin
      seconds_bcd <= start_seconds;
      time_up     <= 1'b0;
    end else if (sec_tick) begin
      seconds_bcd <= bcd_dec(seconds_bcd);
      // flag goes up together with the 00 reading.
      if (seconds_bcd == 8'h01) time_up <= 1'b1;
    end
  end

endmodule

//--- source/disp_hex_mux.sv
// ################################################
// four-digit seven-segment scan, active-low anodes and segments.
// ################################################
module disp_hex_mux #(
  parameter int REFRESH_BITS = 18
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] hex3,
  input  logic [3:0] hex2,
  input  logic [3:0] hex1,
  input  logic [3:0] hex0,
  output logic [3:0] an,
  output logic [6:0] sseg
);

  logic [REFRESH_BITS-1:0] refresh;
  logic [1:0]              sel;
  logic [3:0]              digit;

  always_ff @(posedge clk) begin
    if (rst) refresh <= '0;
    else refresh <= refresh + 1'b1;
  end

  // top two bits pick the digit, so each one stays lit for a quarter of the scan.
  assign sel = refresh[REFRESH_BITS-1 -: 2];

  always_comb begin
    case (sel)
      2'd0:    begin an = 4'b1110; digit = hex0; end
      2'd1:    begin an = 4'b1101; digit = hex1; end
      2'd2:    begin an = 4'b1011; digit = hex2; end
      default: begin an = 4'b0111; digit = hex3; end
    endcase
  end

  // segment order is gfedcba, a low bit lights the segment.
  always_comb begin
    case (digit)
      4'h0:    sseg = 7'b1000000;
      4'h1:    sseg = 7'b1111001;
      4'h2:    sseg = 7'b0100100;
      4'h3:    sseg = 7'b0110000;
      4'h4:    sseg = 7'b0011001;
      4'h5:    sseg = 7'b0010010;
      4'h6:    sseg = 7'b0000010;
      4'h7:    sseg = 7'b1111000;
      4'h8:    sseg = 7'b0000000;
      4'h9:    sseg = 7'b0010000;
      4'ha:    sseg = 7'b0001000;
      4'hb:    sseg = 7'b0000011;
      4'hc:    sseg = 7'b1000110;
      4'hd:    sseg = 7'b0100001;
      4'he:    sseg = 7'b0000110;
      default: sseg = 7'b0001110;
    endcase
  end

endmodule

//--- source/top_mines.sv
// ################################################
// minesweeper game core top: setup, planting, board, timer and display.
// ################################################
module top_mines #(
  parameter int TICKS_PER_SEC = 65_000_000,
  parameter int REFRESH_BITS  = 18
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] level_btn,
  input  logic       pause,
  input  logic [3:0] cell_x,
  input  logic [3:0] cell_y,
  input  logic       left,
  input  logic       right,
  output logic       playing,
  output logic       reveal_valid,
  output logic [3:0] reveal_mines,
  output logic       game_over,
  output logic       game_won,
  output logic [3:0] an,
  output logic [6:0] sseg
);

  logic         start;
  logic [4:0]   board_side;
  logic [5:0]   mine_count;
  logic [7:0]   start_seconds;
  logic [255:0] mine_map;
  logic         plant_done;
  logic         exploded;
  logic         won;
  logic         time_up;
  logic         stop;
  logic [7:0]   mines_left_bcd;
  logic [7:0]   seconds_bcd;

  // ################################################
  // end of round.
  // ################################################
  assign stop     = exploded || won || time_up;
  assign game_won = won;

  // a win beats a late explosion or timeout.
  always_ff @(posedge clk) begin
    if (rst) game_over <= 1'b0;
    else if (start) game_over <= 1'b0;
    else if ((exploded || time_up) && !won) game_over <= 1'b1;
  end

  game_setup u_game_setup (
    .clk, .rst, .level_btn, .start, .level(), .board_side, .mine_count, .start_seconds
  );

  mine_planter u_mine_planter (
    .clk, .rst, .start, .board_side, .mine_count, .mine_map, .plant_done
  );

  mine_field u_mine_field (
    .clk, .rst, .start, .plant_done, .stop, .board_side, .mine_count, .mine_map,
    .cell_x, .cell_y, .left, .right, .playing, .reveal_valid, .reveal_mines,
    .exploded, .won, .mines_left_bcd
  );

  countdown_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_countdown_timer (
    .clk, .rst, .start, .start_seconds, .playing, .pause, .stop, .seconds_bcd, .time_up
  );

  // mines left on the upper pair of digits, seconds on the lower pair.
  disp_hex_mux #(.REFRESH_BITS(REFRESH_BITS)) u_disp (
    .clk, .rst,
    .hex3(mines_left_bcd[7:4]),
    .hex2(mines_left_bcd[3:0]),
    .hex1(seconds_bcd[7:4]),
    .hex0(seconds_bcd[3:0]),
    .an, .sseg
  );

endmodule

//--- verif/tb_top_mines.sv
// ################################################
// testbench for the minesweeper core: level setup, reveals, flags,
// win, explosion, pause and timeout, checked against a reference model.
// ################################################
module tb_top_mines import mines_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICKS = 40;
  // the hard-level timeout dominates at about 2500 cycles, the rest adds under 1000.
  localparam int MAX_CYCLES = 20000;

  localparam int SIDE_TAB  [3] = '{8, 10, 16};
  localparam int COUNT_TAB [3] = '{10, 20, 40};
  localparam int SECS_TAB  [3] = '{99, 80, 60};

  logic             clk = 1'b0;
  logic             rst;
  logic [2:0]       level_btn;
  logic             pause;
  logic [3:0]       cell_x;
  logic [3:0]       cell_y;
  logic             left;
  logic             right;
  logic             playing;
  logic             reveal_valid;
  logic [3:0]       reveal_mines;
  logic             game_over;
  logic             game_won;
  logic [3:0]       an;
  logic [6:0]       sseg;
  logic [3:0]       disp [4];
  logic [CELLS-1:0] model_map;
  logic [CELLS-1:0] model_open;
  int unsigned      rng = 4982;
  int               cur_side;
  int               errors = 0;
  int               checks = 0;
  int               test_err = 0;
  int               cycles = 0;
  int               play_cycle = 0;

  top_mines #(.TICKS_PER_SEC(TICKS), .REFRESH_BITS(4)) i_dut (
    .clk, .rst, .level_btn, .pause, .cell_x, .cell_y, .left, .right,
    .playing, .reveal_valid, .reveal_mines, .game_over, .game_won, .an, .sseg
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ################################################
  // reference model.
  // ################################################
  function automatic logic [3:0] seg_digit(input logic [6:0] seg);
    case (seg)
      7'b1000000: return 4'd0;
      7'b1111001: return 4'd1;
      7'b0100100: return 4'd2;
      7'b0110000: return 4'd3;
      7'b0011001: return 4'd4;
      7'b0010010: return 4'd5;
      7'b0000010: return 4'd6;
      7'b1111000: return 4'd7;
      7'b0000000: return 4'd8;
      7'b0010000: return 4'd9;
      default:    return 4'hf;
    endcase
  endfunction

  // each digit keeps the value last seen while its anode was low.
  always @(negedge clk) begin
    case (an)
      4'b1110: disp[0] = seg_digit(sseg);
      4'b1101: disp[1] = seg_digit(sseg);
      4'b1011: disp[2] = seg_digit(sseg);
      4'b0111: disp[3] = seg_digit(sseg);
      default: begin
        errors++;
        $display("an = %b at %0d ns does not select exactly one digit", an, $time);
      end
    endcase
  end

  function automatic logic [7:0] to_bcd(input int value);
    return {4'(value / 10), 4'(value % 10)};
  endfunction

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // fibonacci LFSR x^16+x^14+x^13+x^11+1, candidate cell from the new value.
  function automatic logic [CELLS-1:0] plant_model(input int side, input int count);
    logic [CELLS-1:0] map;
    logic [15:0]      lfsr;
    int               x;
    int               y;
    int               placed;
    map    = '0;
    lfsr   = MINE_SEED;
    placed = 0;
    while (placed < count) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      x    = lfsr[3:0];
      y    = lfsr[7:4];
      if (x < side && y < side && !map[y * 16 + x]) begin
        map[y * 16 + x] = 1'b1;
        placed++;
      end
    end
    return map;
  endfunction

  function automatic int nb_model(input int x, input int y);
    int n;
    n = 0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        if ((dx != 0 || dy != 0) && x + dx >= 0 && y + dy >= 0 &&
            x + dx < cur_side && y + dy < cur_side) begin
          n += model_map[(y + dy) * 16 + x + dx];
        end
      end
    end
    return n;
  endfunction

  // first safe cell that the model has not opened yet, or -1.
  function automatic int first_closed();
    for (int i = 0; i < CELLS; i++) begin
      if (i % 16 < cur_side && i / 16 < cur_side && !model_map[i] && !model_open[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // ################################################
  // checks and stimulus.
  // ################################################
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s", name, (errors == test_err) ? "ok" : "failing checks");
    test_err = errors;
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_display(input int mines, input int secs);
    compare("mines digits", {disp[3], disp[2]}, to_bcd(mines));
    if (secs >= 0) compare("seconds digits", {disp[1], disp[0]}, to_bcd(secs));
  endtask

  task automatic start_level(input int lvl);
    int n;
    level_btn = 3'b001 << lvl;
    step(1);
    level_btn = 3'b000;
    step(2);
    n = 0;
    while (!playing && n < 2000) begin
      step(1);
      n++;
    end
    if (!playing) begin
      errors++;
      $display("playing did not rise after the press for level %0d", lvl);
    end
    play_cycle = cycles;
    cur_side   = SIDE_TAB[lvl];
    model_map  = plant_model(SIDE_TAB[lvl], COUNT_TAB[lvl]);
    model_open = '0;
  endtask

  // one click pulse, then the reveal strobe is checked on the next two cycles.
  task automatic click(input bit is_left, input int x, input int y, input bit pulse);
    cell_x = 4'(x);
    cell_y = 4'(y);
    left   = is_left;
    right  = !is_left;
    step(1);
    left  = 1'b0;
    right = 1'b0;
    compare("reveal_valid", reveal_valid, pulse);
    if (pulse) begin
      compare("reveal_mines", reveal_mines, nb_model(x, y));
      model_open[y * 16 + x] = 1'b1;
    end
    step(1);
    compare("reveal_valid", reveal_valid, 0);
  endtask

  initial begin
    int         x;
    int         y;
    int         c;
    int         counted;
    int         iter;
    int         mines_q [$];
    rst       = 1'b1;
    level_btn = 3'b000;
    pause     = 1'b0;
    cell_x    = 4'd0;
    cell_y    = 4'd0;
    left      = 1'b0;
    right     = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    compare("an", an, 4'b1110);
    compare("playing", playing, 0);
    compare("reveal_valid", reveal_valid, 0);
    compare("game_over", game_over, 0);
    compare("game_won", game_won, 0);

    for (int lvl = 0; lvl < 3; lvl++) begin
      start_level(lvl);
      step(20);
      check_display(COUNT_TAB[lvl], SECS_TAB[lvl]);
    end
    end_test("setup per level");

    start_level(0);
    for (int i = 0; i < 12; i++) begin
      do begin
        rng = lcg_step(rng);
        x   = (rng >> 16) % cur_side;
        y   = (rng >> 24) % cur_side;
      end while (model_map[y * 16 + x]);
      click(1, x, y, !model_open[y * 16 + x]);
    end
    click(1, x, y, 0);
    click(1, 9, 2, 0);
    click(1, 3, 12, 0);
    end_test("reveal");

    for (int i = 0; i < CELLS; i++) begin
      if (model_map[i]) mines_q.push_back(i);
    end
    click(0, mines_q[0] % 16, mines_q[0] / 16, 0);
    step(20);
    check_display(9, -1);
    click(0, mines_q[0] % 16, mines_q[0] / 16, 0);
    step(20);
    check_display(10, -1);
    foreach (mines_q[i]) begin
      click(0, mines_q[i] % 16, mines_q[i] / 16, 0);
    end
    step(20);
    check_display(0, -1);
    // a flagged mine neither opens nor explodes.
    click(1, mines_q[0] % 16, mines_q[0] / 16, 0);
    step(2);
    compare("game_over", game_over, 0);
    compare("playing", playing, 1);
    // no flags are left, so this cell stays open to a left click.
    c = first_closed();
    click(0, c % 16, c / 16, 0);
    click(1, c % 16, c / 16, 1);
    end_test("flags");

    c = first_closed();
    while (c >= 0) begin
      click(1, c % 16, c / 16, 1);
      c = first_closed();
    end
    // the timer ran on every cycle from the rise of playing up to the edge that set won.
    counted = cycles - play_cycle;
    step(3);
    compare("game_won", game_won, 1);
    compare("game_over", game_over, 0);
    compare("playing", playing, 0);
    step(20);
    check_display(0, SECS_TAB[0] - counted / TICKS);
    step(3 * TICKS);
    check_display(0, SECS_TAB[0] - counted / TICKS);
    end_test("win");

    start_level(0);
    click(1, mines_q[1] % 16, mines_q[1] / 16, 0);
    compare("game_over", game_over, 1);
    compare("game_won", game_won, 0);
    compare("playing", playing, 0);
    c = first_closed();
    click(1, c % 16, c / 16, 0);
    end_test("explode");

    start_level(2);
    counted = 0;
    iter    = 0;
    while (counted < 60 * TICKS) begin
      // a 100-cycle pause lands in the second second of the round.
      pause = (iter >= 70 && iter < 170);
      step(1);
      iter++;
      if (!pause) counted++;
      if (counted % TICKS == 30) check_display(40, 60 - counted / TICKS);
    end
    pause = 1'b0;
    step(2);
    compare("game_over", game_over, 1);
    compare("game_won", game_won, 0);
    step(20);
    check_display(40, 0);
    end_test("timeout and pause");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
source/mines_pkg.sv
source/game_setup.sv
source/mine_planter.sv
source/mine_field.sv
source/countdown_timer.sv
source/disp_hex_mux.sv
source/top_mines.sv
verif/tb_top_mines.sv
